// File: hw/prf_pkg.sv
// Shared widths, counts and types for the physical register file subsystem
// Modules import this package inside their bodies and use scoped names in their headers

package prf_pkg;

    ////////////////////
    // Datapath sizes
    ////////////////////

    // Register value width
    localparam int xlen = 32;

    // Instructions handled per cycle
    localparam int n_way = 2;

    // Source operands per instruction
    localparam int n_src = 2;

    // One read port per source operand per way
    localparam int n_rd = n_way * n_src;

    ////////////////////
    // Register space
    ////////////////////

    // Physical registers, R10K style
    localparam int phys_reg_sz = 64;

    // Index width, log2 of phys_reg_sz
    localparam int preg_w = 6;

    typedef logic [xlen-1:0] data_t;
    typedef logic [preg_w-1:0] preg_idx_t;

    // Hard-wired zero register
    localparam preg_idx_t zero_reg = preg_idx_t'(0);

    ////////////////////
    // Operand fetch FSM
    ////////////////////

    // Idle waits for req, hold keeps ack high, release is the guard cycle after ack falls
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_hold    = 2'd1,
        st_release = 2'd2
    } fetch_state_t;

endpackage

// File: hw/rf_ports_if.sv
// Read and write interfaces of the physical register file
// The write side fans out to regfile and valid table, the read side joins all three blocks

`timescale 1ns/100ps

////////////////////
// Writeback bus
////////////////////

interface rf_write_if;
    import prf_pkg::*;

    // One entry per superscalar way
    logic [n_way-1:0]      en;
    preg_idx_t [n_way-1:0] idx;
    data_t [n_way-1:0]     data;

    // Register file storage side
    modport regfile_wr (input en, input idx, input data);

    // Valid table side, only en and idx matter there
    modport valid_wr (input en, input idx, input data);

endinterface

////////////////////
// Operand read bus
////////////////////

interface rf_read_if;
    import prf_pkg::*;

    // Driven by operand fetch
    preg_idx_t [n_rd-1:0] idx;
    // Driven by regfile, combinational
    data_t [n_rd-1:0]     data;
    // Driven by valid table, combinational
    logic [n_rd-1:0]      rdy;

    modport fetch (output idx, input data, input rdy);
    modport regfile_rd (input idx, output data);
    modport valid_rd (input idx, output rdy);

endinterface

// File: hw/mem_dp.sv
// Generic multi-port memory with combinational reads and optional write forwarding
// Ports are packed arrays, lowest index is way 0; higher write ways take priority

`timescale 1ns/100ps

module mem_dp #(
    parameter int width       = 32,
    parameter int depth       = 64,
    parameter int read_ports  = 2,
    parameter int write_ports = 1,
    parameter bit bypass_en   = 1'b1,
    localparam int aw         = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    // Read side
    input  logic [read_ports-1:0]                 re,
    input  logic [read_ports-1:0][aw-1:0]         raddr,
    output logic [read_ports-1:0][width-1:0]      rdata,
    // Write side
    input  logic [write_ports-1:0]                we,
    input  logic [write_ports-1:0][aw-1:0]        waddr,
    input  logic [write_ports-1:0][width-1:0]     wdata
);

    ////////////////////
    // Storage
    ////////////////////

    // No data reset, contents are defined only once written
    logic [width-1:0] mem [depth];

    // Ways applied in order so the highest way lands last
    // Writes held off while reset is asserted
    always_ff @(posedge clock) begin
        if (rst_n) begin
            for (int w = 0; w < write_ports; w++) begin
                if (we[w]) begin
                    mem[waddr[w]] <= wdata[w];
                end
            end
        end
    end

    ////////////////////
    // Read and bypass
    ////////////////////

    always_comb begin
        for (int r = 0; r < read_ports; r++) begin
            // Disabled port returns zero
            rdata[r] = '0;
            if (re[r]) begin
                rdata[r] = mem[raddr[r]];
                if (bypass_en) begin
                    // Scan in way order, newest matching write wins
                    for (int w = 0; w < write_ports; w++) begin
                        if (we[w] && (waddr[w] == raddr[r])) begin
                            rdata[r] = wdata[w];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hw/regfile.sv
// Physical register file on top of mem_dp, one read port per source operand
// Register 0 always reads zero and ignores writes

`timescale 1ns/100ps

module regfile #(
    parameter int depth = prf_pkg::phys_reg_sz
) (
    input logic clock,
    input logic rst_n,
    rf_write_if.regfile_wr wr,
    rf_read_if.regfile_rd  rd
);
    import prf_pkg::*;

    // Memory address width
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    // Per-port enables with register 0 masked
    logic [n_rd-1:0]  re;
    logic [n_way-1:0] we;

    // Address vectors sized for the memory
    logic [n_rd-1:0][aw-1:0]  raddr;
    logic [n_way-1:0][aw-1:0] waddr;

    // Memory output, already zero on a disabled port
    data_t [n_rd-1:0] rdata;

    ////////////////////
    // Read ports
    ////////////////////

    for (genvar r = 0; r < n_rd; r++) begin : g_rd
        // No memory access for register 0
        assign re[r]      = (rd.idx[r] != zero_reg);
        assign raddr[r]   = aw'(rd.idx[r]);
        assign rd.data[r] = rdata[r];
    end

    ////////////////////
    // Write ports
    ////////////////////

    for (genvar w = 0; w < n_way; w++) begin : g_wr
        // Writes to register 0 are dropped per way
        assign we[w]    = wr.en[w] && (wr.idx[w] != zero_reg);
        assign waddr[w] = aw'(wr.idx[w]);
    end

    // Forwarding on, so a same-cycle writeback shows up on the read
    mem_dp #(
        .width       (xlen),
        .depth       (depth),
        .read_ports  (n_rd),
        .write_ports (n_way),
        .bypass_en   (1'b1)
    ) u_mem (
        .clock (clock),
        .rst_n (rst_n),
        .re    (re),
        .raddr (raddr),
        .rdata (rdata),
        .we    (we),
        .waddr (waddr),
        .wdata (wr.data)
    );

endmodule

// File: hw/prf_valid_table.sv
// Written flag per physical register, set by writeback and cleared by free
// Drives rdy on each read port with same-cycle writeback forwarding

`timescale 1ns/100ps

module prf_valid_table (
    input logic                                    clock,
    input logic                                    rst_n,
    rf_write_if.valid_wr                           wr,
    input logic [prf_pkg::n_way-1:0]               free_en,
    input prf_pkg::preg_idx_t [prf_pkg::n_way-1:0] free_idx,
    rf_read_if.valid_rd                            rd
);
    import prf_pkg::*;

    // One bit per register, cleared on reset
    logic [phys_reg_sz-1:0] written;
    logic [n_rd-1:0]        rdy_c;

    // Frees first, then writebacks, so a write wins a collision
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else begin
            for (int w = 0; w < n_way; w++) begin
                if (free_en[w]) begin
                    written[free_idx[w]] <= 1'b0;
                end
            end
            for (int w = 0; w < n_way; w++) begin
                if (wr.en[w]) begin
                    written[wr.idx[w]] <= 1'b1;
                end
            end
        end
    end

    // Ready if flagged, being written this cycle, or the zero register
    always_comb begin
        for (int r = 0; r < n_rd; r++) begin
            rdy_c[r] = written[rd.idx[r]] || (rd.idx[r] == zero_reg);
            for (int w = 0; w < n_way; w++) begin
                if (wr.en[w] && (wr.idx[w] == rd.idx[r])) begin
                    rdy_c[r] = 1'b1;
                end
            end
        end
    end

    assign rd.rdy = rdy_c;

endmodule

// File: hw/operand_fetch.sv
// Four-phase req/ack front end for the operand reads of two instructions
// Captures data and ready bits at the request edge and holds them until req drops

`timescale 1ns/100ps

module operand_fetch (
    input  logic                                   clock,
    input  logic                                   rst_n,
    // Requester side
    input  logic                                   req,
    input  prf_pkg::preg_idx_t [prf_pkg::n_rd-1:0] rd_idx,
    output logic                                   ack,
    output prf_pkg::data_t [prf_pkg::n_rd-1:0]     opnd_data,
    output logic [prf_pkg::n_rd-1:0]               opnd_rdy,
    // Register file and valid table reads
    rf_read_if.fetch                               rf
);
    import prf_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;

    // High for the single edge that samples the operands
    logic capture;

    ////////////////////
    // Read request
    ////////////////////

    // Indices go straight to the read ports, reads are combinational
    assign rf.idx = rd_idx;

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // Wait for a request
            st_idle: begin
                if (req) begin
                    state_nxt = st_hold;
                end
            end
            // Ack high, operands frozen until the requester lets go
            st_hold: begin
                if (!req) begin
                    state_nxt = st_release;
                end
            end
            // Ack already low, one guard cycle before the next capture
            st_release: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    assign capture = (state == st_idle) && req;

    // Ack follows the hold state, so it rises after the capture edge
    // and falls after the first edge that sees req low
    assign ack = (state == st_hold);

    ////////////////////
    // Operand hold
    ////////////////////

    // Loaded only at capture, later writebacks cannot disturb the held values
    always_ff @(posedge clock) begin
        if (capture) begin
            opnd_data <= rf.data;
            opnd_rdy  <= rf.rdy;
        end
    end

endmodule

// File: hw/prf_top.sv
// Top level of the physical register file subsystem
// Joins regfile, valid table and operand fetch; writeback and free come in from outside

`timescale 1ns/100ps

module prf_top (
    input  logic                                    clock,
    input  logic                                    rst_n,
    // Writeback, one per way
    input  logic [prf_pkg::n_way-1:0]               wb_en,
    input  prf_pkg::preg_idx_t [prf_pkg::n_way-1:0] wb_idx,
    input  prf_pkg::data_t [prf_pkg::n_way-1:0]     wb_data,
    // Free, one per way
    input  logic [prf_pkg::n_way-1:0]               free_en,
    input  prf_pkg::preg_idx_t [prf_pkg::n_way-1:0] free_idx,
    // Operand request handshake
    input  logic                                    req,
    input  prf_pkg::preg_idx_t [prf_pkg::n_rd-1:0]  rd_idx,
    output logic                                    ack,
    output prf_pkg::data_t [prf_pkg::n_rd-1:0]      opnd_data,
    output logic [prf_pkg::n_rd-1:0]                opnd_rdy
);
    import prf_pkg::*;

    ////////////////////
    // Internal buses
    ////////////////////

    rf_write_if wb_if ();
    rf_read_if  rd_if ();

    // Writeback bus straight from the top-level ports
    assign wb_if.en   = wb_en;
    assign wb_if.idx  = wb_idx;
    assign wb_if.data = wb_data;

    ////////////////////
    // Blocks
    ////////////////////

    // Register storage, data side of the read bus
    regfile #(
        .depth (phys_reg_sz)
    ) u_regfile (
        .clock (clock),
        .rst_n (rst_n),
        .wr    (wb_if.regfile_wr),
        .rd    (rd_if.regfile_rd)
    );

    // Written flags, rdy side of the read bus
    prf_valid_table u_valid (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (wb_if.valid_wr),
        .free_en  (free_en),
        .free_idx (free_idx),
        .rd       (rd_if.valid_rd)
    );

    // Request front end, drives the read indices
    operand_fetch u_fetch (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .rd_idx    (rd_idx),
        .ack       (ack),
        .opnd_data (opnd_data),
        .opnd_rdy  (opnd_rdy),
        .rf        (rd_if.fetch)
    );

endmodule

// File: dv/prf_props.sv
// Handshake and hold checks for operand_fetch, attached with bind below
// n_fail counts assertion failures so the testbench can read them at the end

`timescale 1ns/100ps

module prf_props (
    input logic                               clock,
    input logic                               rst_n,
    input logic                               req,
    input logic                               ack,
    input prf_pkg::data_t [prf_pkg::n_rd-1:0] opnd_data,
    input logic [prf_pkg::n_rd-1:0]           opnd_rdy
);
    import prf_pkg::*;

    int unsigned n_fail = 0;

    ////////////////////
    // Handshake
    ////////////////////

    // Ack rises after the edge that sampled req high
    a_ack_after_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            n_fail++;
            $error("ack rose without a request");
        end

    // Async reset keeps the FSM idle
    a_ack_low_in_reset: assert property (@(posedge clock) !rst_n |-> !ack)
        else begin
            n_fail++;
            $error("ack high during reset");
        end

    ////////////////////
    // Operand hold
    ////////////////////

    // Values frozen from the cycle after capture until ack drops
    a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(opnd_data) && $stable(opnd_rdy))
        else begin
            n_fail++;
            $error("held operands changed while ack high");
        end

endmodule

bind operand_fetch prf_props u_props (
    .clock     (clock),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .opnd_data (opnd_data),
    .opnd_rdy  (opnd_rdy)
);

// File: dv/tb_prf_top.sv
// Directed testbench for prf_top, inputs driven on the falling edge
// A register model gives expected data and ready bits for every operand fetch

`timescale 1ns/100ps

module tb_prf_top;
    import prf_pkg::*;

    localparam int ack_timeout = 20;

    logic clock;
    logic rst_n;
    logic [n_way-1:0]      wb_en;
    preg_idx_t [n_way-1:0] wb_idx;
    data_t [n_way-1:0]     wb_data;
    logic [n_way-1:0]      free_en;
    preg_idx_t [n_way-1:0] free_idx;
    logic                  req;
    preg_idx_t [n_rd-1:0]  rd_idx;
    logic                  ack;
    data_t [n_rd-1:0]      opnd_data;
    logic [n_rd-1:0]       opnd_rdy;

    // Register model and the expectation snapshot taken at capture
    data_t model_data [phys_reg_sz];
    logic  model_written [phys_reg_sz];
    data_t exp_data [n_rd];
    logic  exp_rdy [n_rd];
    int    seed = 48925;

    prf_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped on first failure");
    endtask

    task automatic compare_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_rdy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Rdy in every slot, data only where a value is defined
    task automatic check_operands();
        for (int r = 0; r < n_rd; r++) begin
            compare_rdy($sformatf("opnd_rdy[%0d]", r), opnd_rdy[r], exp_rdy[r]);
            if (exp_rdy[r]) begin
                compare_data($sformatf("opnd_data[%0d]", r), opnd_data[r], exp_data[r]);
            end
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_write(input int way, input preg_idx_t idx, input data_t data);
        wb_en[way]   = 1'b1;
        wb_idx[way]  = idx;
        wb_data[way] = data;
    endtask

    task automatic drive_free(input int way, input preg_idx_t idx);
        free_en[way]  = 1'b1;
        free_idx[way] = idx;
    endtask

    // Model takes the driven ports, frees first so a write wins, higher way last
    task automatic next_cycle();
        for (int w = 0; w < n_way; w++) begin
            if (free_en[w]) begin
                model_written[free_idx[w]] = 1'b0;
            end
        end
        for (int w = 0; w < n_way; w++) begin
            if (wb_en[w] && (wb_idx[w] != zero_reg)) begin
                model_written[wb_idx[w]] = 1'b1;
                model_data[wb_idx[w]]    = wb_data[w];
            end
        end
        @(negedge clock);
        wb_en   = '0;
        free_en = '0;
    endtask

    // Raise req, wait for ack, snapshot the model and check the operands
    task automatic fetch_start(input preg_idx_t i0, input preg_idx_t i1,
                               input preg_idx_t i2, input preg_idx_t i3);
        int cnt;
        cnt       = 0;
        rd_idx[0] = i0;
        rd_idx[1] = i1;
        rd_idx[2] = i2;
        rd_idx[3] = i3;
        req       = 1'b1;
        next_cycle();
        while (!ack) begin
            if (cnt == ack_timeout) begin
                $display("Timeout: ack did not rise after req was raised");
                stop_with_failure();
            end
            cnt++;
            next_cycle();
        end
        for (int r = 0; r < n_rd; r++) begin
            exp_rdy[r]  = (rd_idx[r] == zero_reg) || model_written[rd_idx[r]];
            exp_data[r] = (rd_idx[r] == zero_reg) ? '0 : model_data[rd_idx[r]];
        end
        check_operands();
    endtask

    task automatic fetch_end();
        int cnt;
        cnt = 0;
        req = 1'b0;
        next_cycle();
        while (ack) begin
            if (cnt == ack_timeout) begin
                $display("Timeout: ack did not fall after req was dropped");
                stop_with_failure();
            end
            cnt++;
            next_cycle();
        end
    endtask

    task automatic fetch_check(input preg_idx_t i0, input preg_idx_t i1,
                               input preg_idx_t i2, input preg_idx_t i3);
        fetch_start(i0, i1, i2, i3);
        fetch_end();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset();
        compare_rdy("ack", ack, 1'b0);
        fetch_check(6'd1, 6'd2, 6'd3, 6'd4);
        fetch_check(zero_reg, zero_reg, zero_reg, zero_reg);
    endtask

    task automatic test_write_read();
        for (int i = 0; i < 4; i++) begin
            drive_write(0, preg_idx_t'(5 + 2 * i), $random(seed));
            drive_write(1, preg_idx_t'(6 + 2 * i), $random(seed));
            next_cycle();
        end
        fetch_check(6'd5, 6'd6, 6'd7, 6'd8);
        fetch_check(6'd9, 6'd10, 6'd11, 6'd12);
    endtask

    task automatic test_zero_reg();
        drive_write(0, zero_reg, $random(seed) | 32'h1);
        drive_write(1, 6'd13, $random(seed));
        next_cycle();
        fetch_check(zero_reg, 6'd13, zero_reg, 6'd13);
    endtask

    // Writeback on the req edge is forwarded, one during hold is not
    task automatic test_forwarding();
        // Back to idle first so the capture edge is also the writeback edge
        next_cycle();
        drive_write(0, 6'd20, $random(seed));
        fetch_start(6'd20, 6'd5, 6'd20, 6'd6);
        drive_write(1, 6'd20, $random(seed));
        next_cycle();
        next_cycle();
        check_operands();
        fetch_end();
        fetch_check(6'd20, 6'd20, 6'd5, 6'd6);
    endtask

    task automatic test_free();
        drive_write(0, 6'd30, $random(seed));
        drive_write(1, 6'd31, $random(seed));
        next_cycle();
        drive_free(0, 6'd30);
        next_cycle();
        fetch_check(6'd30, 6'd31, 6'd30, 6'd31);
        // Free and write on the same register, across both way orders
        drive_free(0, 6'd31);
        drive_write(1, 6'd31, $random(seed));
        drive_free(1, 6'd32);
        drive_write(0, 6'd32, $random(seed));
        next_cycle();
        fetch_check(6'd31, 6'd32, 6'd30, 6'd31);
    endtask

    task automatic test_dual_write();
        drive_write(0, 6'd40, $random(seed));
        drive_write(1, 6'd40, $random(seed));
        next_cycle();
        fetch_check(6'd40, 6'd40, 6'd40, 6'd40);
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_en    = '0;
        wb_idx   = '0;
        wb_data  = '0;
        free_en  = '0;
        free_idx = '0;
        req      = 1'b0;
        rd_idx   = '0;
        for (int i = 0; i < phys_reg_sz; i++) begin
            model_written[i] = 1'b0;
        end
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        test_reset();
        test_write_read();
        test_zero_reg();
        test_forwarding();
        test_free();
        test_dual_write();
        if (uut.u_fetch.u_props.n_fail == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Assertion failures reported in operand_fetch");
            stop_with_failure();
        end
    end

endmodule

// File: sim.f
hw/prf_pkg.sv
hw/rf_ports_if.sv
hw/mem_dp.sv
hw/regfile.sv
hw/prf_valid_table.sv
hw/operand_fetch.sv
hw/prf_top.sv
dv/prf_props.sv
dv/tb_prf_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_prf_top
FILELIST   ?= sim.f
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
OBJ_DIR    ?= obj_dir
PASS_MSG   := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
